//--- include/tilevid_defs.svh
`ifndef TILEVID_DEFS_SVH
`define TILEVID_DEFS_SVH

// Screen geometry in pixels and lines
`define TV_HTOTAL    64
`define TV_HVIS      48
`define TV_VTOTAL    40
`define TV_VVIS      32

// Sync pulse windows
`define TV_HS_START  52
`define TV_HS_END    55
`define TV_VS_START  34
`define TV_VS_END    35

`define TV_LAYERS    3
`define TV_ROM_AW    16
`define TV_PIX_LAT   3

// CPU write bus
`define TV_CPU_AW    6
`define TV_CPU_DW    16
`define TV_PAL_SIZE  48

`endif

//--- run_sim.sh
#!/usr/bin/env bash
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tilevid_tb -f tilevid.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtilevid_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Test completed successfully" "$log"; then
    echo "PASS"
    exit 0
fi
echo "FAIL"
exit 1

//--- sim/tilevid_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "tilevid_defs.svh"

module tilevid_tb import tilevid_pkg::*; ();

    localparam int FRAME_PIX  = `TV_HTOTAL * `TV_VTOTAL;
    localparam int RUN_CLOCKS = 4 * FRAME_PIX * 2 + 2 * `TV_PIX_LAT;
    localparam int TIMEOUT    = 4 * FRAME_PIX * 2 + 500;
    // CPU writes land on this line of each vertical blank
    localparam int WRITE_LINE = 33;

    logic                  clk;
    logic                  arst_n;
    logic                  rom_cs;
    logic [`TV_ROM_AW-1:0] rom_addr;
    logic [31:0]           rom_data;
    logic                  rom_ok;
    logic                  cpu_we;
    logic [`TV_CPU_AW-1:0] cpu_addr;
    logic [`TV_CPU_DW-1:0] cpu_din;
    logic                  pxl_cen, pxl2_cen;
    logic                  HS, VS;
    logic                  LHBL_dly, LVBL_dly;
    logic [4:0]            red, green, blue;

    // Reference state
    rgb_t       pal_m [`TV_PAL_SIZE];
    logic [7:0] scroll_x [`TV_LAYERS];
    logic [7:0] scroll_y [`TV_LAYERS];
    logic [21:0] wq [$];
    logic [`TV_ROM_AW-1:0] req_addr;

    int seed = 32'h10f4_a006;
    int rgb_errs = 0;
    int bit_errs = 0;
    int addr_errs = 0;
    int cycles = 0;
    int rom_wait = 0;
    int rom_delay = 1;

    tilevid_game uut (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .rom_cs   ( rom_cs   ),
        .rom_addr ( rom_addr ),
        .rom_data ( rom_data ),
        .rom_ok   ( rom_ok   ),
        .cpu_we   ( cpu_we   ),
        .cpu_addr ( cpu_addr ),
        .cpu_din  ( cpu_din  ),
        .pxl_cen  ( pxl_cen  ),
        .pxl2_cen ( pxl2_cen ),
        .HS       ( HS       ),
        .VS       ( VS       ),
        .LHBL_dly ( LHBL_dly ),
        .LVBL_dly ( LVBL_dly ),
        .red      ( red      ),
        .green    ( green    ),
        .blue     ( blue     )
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("Timeout: run did not end within %0d clock cycles", TIMEOUT);
            $display("Test failed");
            $finish;
        end
    end

    // Graphics ROM contents, sparse enough to leave transparent pixels
    function automatic logic [31:0] rom_word(logic [15:0] a);
        logic [31:0] m;
        m = {a, a} * 32'h045d_9f3b;
        m = m ^ (m >> 15);
        return m & (m >> 3);
    endfunction

    function automatic rgb_t expected_colour(int h, int v);
        int          l, x, y;
        logic [15:0] a;
        logic [31:0] w;
        pix_t        nib;
        pal_addr_t   entry;
        bit          found;
        entry = {2'd2, 4'd0};
        found = 1'b0;
        for (l = 0; l < `TV_LAYERS; l++) begin
            x   = (h + scroll_x[l]) % 256;
            y   = (v + scroll_y[l]) % 256;
            a   = {1'b0, l[1:0], y[7:0], x[7:3]};
            w   = rom_word(a);
            nib = w[31 - 4 * (x % 8) -: 4];
            if (!found && nib != 4'd0) begin
                entry = {l[1:0], nib};
                found = 1'b1;
            end
        end
        return pal_m[entry];
    endfunction

    task automatic check_rgb(input string name, input rgb_t exp, input rgb_t act);
        if (exp !== act) begin
            rgb_errs++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (exp !== act) begin
            bit_errs++;
            $display("mismatch %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input logic [`TV_ROM_AW-1:0] exp,
                              input logic [`TV_ROM_AW-1:0] act);
        if (exp !== act) begin
            addr_errs++;
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic queue_writes(input bit setup);
        int          n;
        logic [15:0] d;
        if (setup) begin
            for (n = 0; n < `TV_PAL_SIZE; n++) begin
                d = 16'($random(seed));
                wq.push_back({6'(n), d});
            end
        end else begin
            repeat (8) begin
                n = {$random(seed)} % `TV_PAL_SIZE;
                d = 16'($random(seed));
                wq.push_back({6'(n), d});
            end
            for (n = 0; n < 2 * `TV_LAYERS; n++) begin
                d = 16'($random(seed));
                // Scroll x is kept on tile boundaries for the whole-tile shifter
                if (n % 2 == 0)
                    d[2:0] = 3'd0;
                wq.push_back({6'(`TV_PAL_SIZE + n), d});
            end
        end
    endtask

    task automatic apply_write();
        int l;
        {cpu_addr, cpu_din} = wq.pop_front();
        cpu_we = 1'b1;
        if (cpu_addr < `TV_PAL_SIZE) begin
            pal_m[cpu_addr] = rgb_t'(cpu_din[14:0]);
        end else begin
            l = (int'(cpu_addr) - `TV_PAL_SIZE) / 2;
            if (cpu_addr[0] == 1'b0)
                scroll_x[l] = cpu_din[7:0];
            else
                scroll_y[l] = cpu_din[7:0];
        end
    endtask

    // Answers a held rom_cs after 1 to 3 cycles with a one-cycle ok
    task automatic drive_rom();
        if (rom_ok) begin
            rom_ok = 1'b0;
        end else if (rom_cs) begin
            if (rom_wait == 0) begin
                rom_delay = 1 + ({$random(seed)} % 3);
                req_addr  = rom_addr;
            end else begin
                // Address stays put while the request is held
                check_addr("rom_addr held", req_addr, rom_addr);
            end
            rom_wait++;
            if (rom_wait >= rom_delay) begin
                rom_ok   = 1'b1;
                rom_data = rom_word(rom_addr);
                rom_wait = 0;
            end
        end
    endtask

    initial begin
        int   c, p, h, v, q, qh, qv;
        bit   blank;
        rgb_t act;
        arst_n   = 1'b0;
        rom_data = '0;
        rom_ok   = 1'b0;
        cpu_we   = 1'b0;
        cpu_addr = '0;
        cpu_din  = '0;
        req_addr = '0;
        for (h = 0; h < `TV_LAYERS; h++) begin
            scroll_x[h] = '0;
            scroll_y[h] = '0;
        end
        repeat (5) begin
            @(negedge clk);
            check_bit("rom_cs in reset", 1'b0, rom_cs);
        end
        arst_n = 1'b1;

        for (c = 1; c <= RUN_CLOCKS; c++) begin
            @(negedge clk);
            p = c / 2;
            h = p % `TV_HTOTAL;
            v = (p / `TV_HTOTAL) % `TV_VTOTAL;

            cpu_we = 1'b0;
            if (c % 2 == 0 && p % FRAME_PIX == WRITE_LINE * `TV_HTOTAL && p / FRAME_PIX < 3)
                queue_writes(p < FRAME_PIX);
            if (wq.size() > 0)
                apply_write();
            drive_rom();

            check_bit("pxl_cen", c % 2 == 1, pxl_cen);
            check_bit("pxl2_cen", 1'b1, pxl2_cen);
            check_bit("HS", h >= `TV_HS_START && h <= `TV_HS_END, HS);
            check_bit("VS", v >= `TV_VS_START && v <= `TV_VS_END, VS);

            act = rgb_t'({red, green, blue});
            if (p < `TV_PIX_LAT) begin
                check_bit("LHBL_dly after reset", 1'b0, LHBL_dly);
                check_bit("LVBL_dly after reset", 1'b0, LVBL_dly);
                check_rgb("colour after reset", '0, act);
            end else begin
                q     = p - `TV_PIX_LAT;
                qh    = q % `TV_HTOTAL;
                qv    = (q / `TV_HTOTAL) % `TV_VTOTAL;
                blank = qh >= `TV_HVIS || qv >= `TV_VVIS;
                check_bit("LHBL_dly", qh < `TV_HVIS, LHBL_dly);
                check_bit("LVBL_dly", qv < `TV_VVIS, LVBL_dly);
                if (blank)
                    check_rgb($sformatf("blank h=%0d v=%0d", qh, qv), '0, act);
                // Palette holds no defined colours before the first frame ends
                else if (q >= FRAME_PIX)
                    check_rgb($sformatf("pixel h=%0d v=%0d", qh, qv),
                              expected_colour(qh, qv), act);
            end
        end

        $display("Errors: %0d colour, %0d sync or blank, %0d ROM address",
                 rgb_errs, bit_errs, addr_errs);
        if (rgb_errs == 0 && bit_errs == 0 && addr_errs == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src/tilevid_game.sv
`timescale 1ns/1ps
`default_nettype none

`include "tilevid_defs.svh"

module tilevid_game import tilevid_pkg::*; (
    input  wire                   clk,
    input  wire                   arst_n,
    // Graphics ROM
    output logic                  rom_cs,
    output logic [`TV_ROM_AW-1:0] rom_addr,
    input  wire  [31:0]           rom_data,
    input  wire                   rom_ok,
    // CPU writes
    input  wire                   cpu_we,
    input  wire  [`TV_CPU_AW-1:0] cpu_addr,
    input  wire  [`TV_CPU_DW-1:0] cpu_din,
    // Video
    output logic                  pxl_cen,
    output logic                  pxl2_cen,
    output logic                  HS,
    output logic                  VS,
    output logic                  LHBL_dly,
    output logic                  LVBL_dly,
    output logic [4:0]            red,
    output logic [4:0]            green,
    output logic [4:0]            blue
);

    hpos_t hdump;
    vpos_t vdump;
    logic  LHBL, LVBL;
    pix_t  pix [`TV_LAYERS];

    tilevid_rom_if rom_bus [`TV_LAYERS] ();

    tilevid_timing u_timing (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .pxl_cen  ( pxl_cen  ),
        .pxl2_cen ( pxl2_cen ),
        .HS       ( HS       ),
        .VS       ( VS       ),
        .LHBL     ( LHBL     ),
        .LVBL     ( LVBL     ),
        .hdump    ( hdump    ),
        .vdump    ( vdump    )
    );

    genvar i;
    generate
        for (i = 0; i < `TV_LAYERS; i++) begin : g_layer
            tilevid_layer #(.LAYER_ID(i)) u_layer (
                .clk      ( clk        ),
                .arst_n   ( arst_n     ),
                .pxl_cen  ( pxl_cen    ),
                .hdump    ( hdump      ),
                .vdump    ( vdump      ),
                .cpu_we   ( cpu_we     ),
                .cpu_addr ( cpu_addr   ),
                .cpu_din  ( cpu_din    ),
                .rom      ( rom_bus[i] ),
                .pix      ( pix[i]     )
            );
        end
    endgenerate

    tilevid_rom_arb u_arb (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .req      ( rom_bus  ),
        .rom_cs   ( rom_cs   ),
        .rom_addr ( rom_addr ),
        .rom_data ( rom_data ),
        .rom_ok   ( rom_ok   )
    );

    tilevid_mixer u_mixer (
        .clk      ( clk      ),
        .arst_n   ( arst_n   ),
        .pxl_cen  ( pxl_cen  ),
        .LHBL     ( LHBL     ),
        .LVBL     ( LVBL     ),
        .pix      ( pix      ),
        .cpu_we   ( cpu_we   ),
        .cpu_addr ( cpu_addr ),
        .cpu_din  ( cpu_din  ),
        .LHBL_dly ( LHBL_dly ),
        .LVBL_dly ( LVBL_dly ),
        .red      ( red      ),
        .green    ( green    ),
        .blue     ( blue     )
    );

endmodule

`default_nettype wire

//--- src/tilevid_layer.sv
`timescale 1ns/1ps
`default_nettype none

`include "tilevid_defs.svh"

module tilevid_layer import tilevid_pkg::*; #(
    parameter int LAYER_ID = 0
) (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire                   pxl_cen,
    input  hpos_t                 hdump,
    input  vpos_t                 vdump,
    input  wire                   cpu_we,
    input  wire  [`TV_CPU_AW-1:0] cpu_addr,
    input  wire  [`TV_CPU_DW-1:0] cpu_din,
    tilevid_rom_if.layer          rom,
    output pix_t                  pix
);

    localparam int SCRX_ADDR = `TV_PAL_SIZE + 2 * LAYER_ID;
    localparam int SCRY_ADDR = SCRX_ADDR + 1;

    scroll_t     scr_x, scr_y;
    scroll_t     col_x;
    scroll_t     fy;
    logic [4:0]  ftile;
    logic [31:0] hold, cur;
    logic        hold_valid, stale, line_ok;
    logic        restart, visible, consume, first;
    vpos_t       vnext;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scr_x <= '0;
            scr_y <= '0;
        end else if (cpu_we) begin
            if (cpu_addr == `TV_CPU_AW'(SCRX_ADDR))
                scr_x <= cpu_din[7:0];
            if (cpu_addr == `TV_CPU_AW'(SCRY_ADDR))
                scr_y <= cpu_din[7:0];
        end
    end

    assign col_x   = scroll_t'(hdump) + scr_x;
    assign vnext   = (vdump == vpos_t'(`TV_VTOTAL - 1)) ? '0 : vdump + 1'b1;
    // Next line's first tile is fetched from the start of horizontal blank
    assign restart = pxl_cen && (hdump == hpos_t'(`TV_HVIS));
    assign visible = (hdump < hpos_t'(`TV_HVIS)) && (vdump < vpos_t'(`TV_VVIS));
    assign first   = (hdump == '0) || (col_x[2:0] == 3'd0);
    assign consume = pxl_cen && visible && line_ok && first;

    // Tile fetch
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rom.cs     <= 1'b0;
            hold_valid <= 1'b0;
            stale      <= 1'b0;
            line_ok    <= 1'b0;
            ftile      <= '0;
            fy         <= '0;
        end else begin
            if (rom.cs && rom.ok) begin
                rom.cs <= 1'b0;
                if (!stale) begin
                    hold_valid <= 1'b1;
                    ftile      <= ftile + 1'b1;
                end
                stale <= 1'b0;
            end else if (!rom.cs && !hold_valid) begin
                rom.cs <= 1'b1;
            end
            if (consume)
                hold_valid <= 1'b0;
            if (restart) begin
                line_ok    <= 1'b1;
                hold_valid <= 1'b0;
                ftile      <= scr_x[7:3];
                fy         <= scroll_t'(vnext) + scr_y;
                // A request still in flight belongs to the old line
                stale      <= rom.cs && !rom.ok;
            end
        end
    end

    // Address is captured when the request opens and held until ok
    always_ff @(posedge clk) begin
        if (!rom.cs && !hold_valid)
            rom.addr <= {1'b0, 2'(LAYER_ID), fy, ftile};
        if (rom.cs && rom.ok && !stale)
            hold <= rom.data;
    end

    // Pixel shifter, tile moves in at the boundary
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            if (consume)
                cur <= hold << 4;
            else
                cur <= cur << 4;
            if (visible && line_ok)
                pix <= first ? hold[31 - 4 * col_x[2:0] -: 4] : cur[31:28];
            else
                pix <= '0;
        end
    end

    a_cs_held: assert property (
        @(posedge clk) disable iff (!arst_n)
        rom.cs && !rom.ok |=> rom.cs
    );

    a_no_underrun: assert property (
        @(posedge clk) disable iff (!arst_n)
        consume |-> hold_valid
    );

endmodule

`default_nettype wire

//--- src/tilevid_mixer.sv
`timescale 1ns/1ps
`default_nettype none

`include "tilevid_defs.svh"

module tilevid_mixer import tilevid_pkg::*; (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire                   pxl_cen,
    input  wire                   LHBL,
    input  wire                   LVBL,
    input  pix_t                  pix [`TV_LAYERS],
    input  wire                   cpu_we,
    input  wire  [`TV_CPU_AW-1:0] cpu_addr,
    input  wire  [`TV_CPU_DW-1:0] cpu_din,
    output logic                  LHBL_dly,
    output logic                  LVBL_dly,
    output logic [4:0]            red,
    output logic [4:0]            green,
    output logic [4:0]            blue
);

    rgb_t                   pal [`TV_PAL_SIZE];
    pal_addr_t              win;
    pal_addr_t              sel;
    rgb_t                   rgb;
    logic [`TV_PIX_LAT-1:0] hb_dly, vb_dly;

    always_ff @(posedge clk) begin
        if (cpu_we && cpu_addr < `TV_CPU_AW'(`TV_PAL_SIZE))
            pal[cpu_addr] <= rgb_t'(cpu_din[14:0]);
    end

    // Layer 0 in front, backdrop is entry {2,0}
    always_comb begin
        win = {2'd2, 4'd0};
        for (int k = `TV_LAYERS - 1; k >= 0; k--) begin
            if (pix[k] != '0)
                win = {layer_t'(k), pix[k]};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sel    <= '0;
            rgb    <= '0;
            hb_dly <= '0;
            vb_dly <= '0;
        end else if (pxl_cen) begin
            sel    <= win;
            hb_dly <= {hb_dly[`TV_PIX_LAT-2:0], LHBL};
            vb_dly <= {vb_dly[`TV_PIX_LAT-2:0], LVBL};
            // Black while either blank is active
            if (hb_dly[`TV_PIX_LAT-2] && vb_dly[`TV_PIX_LAT-2])
                rgb <= pal[sel];
            else
                rgb <= '0;
        end
    end

    assign LHBL_dly = hb_dly[`TV_PIX_LAT-1];
    assign LVBL_dly = vb_dly[`TV_PIX_LAT-1];
    assign red      = rgb.r;
    assign green    = rgb.g;
    assign blue     = rgb.b;

endmodule

`default_nettype wire

//--- src/tilevid_pkg.sv
`default_nettype none

package tilevid_pkg;

    // Colour index of one layer pixel, 0 is transparent
    typedef logic [3:0] pix_t;

    typedef struct packed {
        logic [4:0] r;
        logic [4:0] g;
        logic [4:0] b;
    } rgb_t;

    typedef logic [1:0] layer_t;

    // Raster counters
    typedef logic [5:0] hpos_t;
    typedef logic [5:0] vpos_t;

    // Scrolled coordinates wrap at 256
    typedef logic [7:0] scroll_t;

    // Palette entry address {layer, index}
    typedef logic [5:0] pal_addr_t;

endpackage

`default_nettype wire

//--- src/tilevid_rom_arb.sv
`timescale 1ns/1ps
`default_nettype none

`include "tilevid_defs.svh"

module tilevid_rom_arb import tilevid_pkg::*; (
    input  wire                   clk,
    input  wire                   arst_n,
    tilevid_rom_if.arb            req [`TV_LAYERS],
    output logic                  rom_cs,
    output logic [`TV_ROM_AW-1:0] rom_addr,
    input  wire  [31:0]           rom_data,
    input  wire                   rom_ok
);

    logic [`TV_LAYERS-1:0] cs_vec;
    logic [`TV_ROM_AW-1:0] addr_vec [`TV_LAYERS];
    logic                  busy;
    layer_t                gnt;
    layer_t                ptr;
    layer_t                pick;
    logic                  any;

    genvar i;
    generate
        for (i = 0; i < `TV_LAYERS; i++) begin : g_port
            assign cs_vec[i]   = req[i].cs;
            assign addr_vec[i] = req[i].addr;
            assign req[i].data = rom_data;
            // Only the granted layer sees ok
            assign req[i].ok   = rom_ok && busy && (gnt == layer_t'(i));
        end
    endgenerate

    // First requester at or after the pointer
    always_comb begin
        int j;
        pick = ptr;
        any  = 1'b0;
        for (int k = `TV_LAYERS - 1; k >= 0; k--) begin
            j = int'(ptr) + k;
            if (j >= `TV_LAYERS)
                j = j - `TV_LAYERS;
            if (cs_vec[j]) begin
                pick = layer_t'(j);
                any  = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
            gnt  <= '0;
            ptr  <= '0;
        end else if (!busy) begin
            if (any) begin
                busy <= 1'b1;
                gnt  <= pick;
            end
        end else if (rom_ok) begin
            busy <= 1'b0;
            ptr  <= (gnt == layer_t'(`TV_LAYERS - 1)) ? '0 : gnt + 1'b1;
        end
    end

    assign rom_cs   = busy;
    assign rom_addr = addr_vec[gnt];

    a_ok_needs_cs: assert property (
        @(posedge clk) disable iff (!arst_n)
        rom_ok |-> rom_cs
    );

endmodule

`default_nettype wire

//--- src/tilevid_rom_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "tilevid_defs.svh"

interface tilevid_rom_if;

    logic                   cs;
    logic [`TV_ROM_AW-1:0]  addr;
    // Eight pixels, leftmost in the top nibble
    logic [31:0]            data;
    logic                   ok;

    modport layer (
        output cs,
        output addr,
        input  data,
        input  ok
    );

    modport arb (
        input  cs,
        input  addr,
        output data,
        output ok
    );

endinterface

`default_nettype wire

//--- src/tilevid_timing.sv
`timescale 1ns/1ps
`default_nettype none

`include "tilevid_defs.svh"

module tilevid_timing import tilevid_pkg::*; (
    input  wire   clk,
    input  wire   arst_n,
    output logic  pxl_cen,
    output logic  pxl2_cen,
    output logic  HS,
    output logic  VS,
    output logic  LHBL,
    output logic  LVBL,
    output hpos_t hdump,
    output vpos_t vdump
);

    // Full rate enable
    assign pxl2_cen = 1'b1;

    // Half rate enable, first high on the second clock out of reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pxl_cen <= 1'b0;
        end else begin
            pxl_cen <= ~pxl_cen;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hdump <= '0;
            vdump <= '0;
        end else if (pxl_cen) begin
            if (hdump == hpos_t'(`TV_HTOTAL - 1)) begin
                hdump <= '0;
                if (vdump == vpos_t'(`TV_VTOTAL - 1))
                    vdump <= '0;
                else
                    vdump <= vdump + 1'b1;
            end else begin
                hdump <= hdump + 1'b1;
            end
        end
    end

    // Sync and blanking decoded straight from the counters
    assign HS   = (hdump >= hpos_t'(`TV_HS_START)) && (hdump <= hpos_t'(`TV_HS_END));
    assign VS   = (vdump >= vpos_t'(`TV_VS_START)) && (vdump <= vpos_t'(`TV_VS_END));
    assign LHBL = hdump < hpos_t'(`TV_HVIS);
    assign LVBL = vdump < vpos_t'(`TV_VVIS);

    a_vdump_range: assert property (
        @(posedge clk) disable iff (!arst_n)
        vdump < `TV_VTOTAL
    );

endmodule

`default_nettype wire

//--- tilevid.f
+incdir+include
src/tilevid_pkg.sv
src/tilevid_rom_if.sv
src/tilevid_timing.sv
src/tilevid_rom_arb.sv
src/tilevid_layer.sv
src/tilevid_mixer.sv
src/tilevid_game.sv
sim/tilevid_tb.sv
